// File: source/ioPkg.sv
package ioPkg;

	// ----------------------------------------
	// Bus and register widths
	// ----------------------------------------
	localparam int dataWidth = 16;	// Register and bus word

	// ----------------------------------------
	// Interrupt sources
	// ----------------------------------------
	localparam int irqCount    = 11;
	localparam int irqVbl      = 0;	// Arrives from the video clock domain
	localparam int irqGpuCmd   = 1;
	localparam int irqCdrom    = 2;
	localparam int irqDma      = 3;
	localparam int irqTimer0   = 4;	// Timers occupy 4 to 6
	localparam int irqTimer1   = 5;
	localparam int irqTimer2   = 6;
	localparam int irqPad      = 7;
	localparam int irqSio      = 8;
	localparam int irqSpu      = 9;
	localparam int irqLightpen = 10;

	// ----------------------------------------
	// Register map
	// ----------------------------------------
	localparam logic [7:0] addrIrqStatus   = 8'h00;
	localparam logic [7:0] addrIrqMask     = 8'h01;
	localparam logic [7:0] addrCounterBase = 8'h10;
	localparam int         counterStride   = 4;	// Words per counter block

	// Offsets inside one counter block
	localparam logic [1:0] cntValueOfs  = 2'd0;
	localparam logic [1:0] cntModeOfs   = 2'd1;
	localparam logic [1:0] cntTargetOfs = 2'd2;

	// Counter mode bits
	localparam int modeEnable        = 0;
	localparam int modeResetOnTarget = 3;
	localparam int modeIrqOnTarget   = 4;
	localparam int modeIrqOnOverflow = 5;

endpackage

// File: source/sigXDomain.sv
`timescale 1ns/100ps

module sigXDomain (
	input  logic clk,
	input  logic reset,
	input  logic in,
	output logic out
);

	logic meta;	// First stage, may go metastable

	always_ff @(posedge clk) begin
		if (reset) begin
			meta <= 1'b0;
			out  <= 1'b0;
		end else begin
			meta <= in;
			out  <= meta;
		end
	end

	// Output only ever moves to what the input held two edges back
	assert property (@(posedge clk) disable iff (reset)
		$changed(out) |-> (out == $past(in, 2)))
		else $error("sigXDomain: output changed to a value not seen two edges earlier");

endmodule

// File: source/irqController.sv
`timescale 1ns/100ps

module irqController #(
	parameter int irqBits = 11
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       sel,
	input  logic                       regHigh,	// Mask when set, status otherwise
	input  logic                       write,
	input  logic [ioPkg::dataWidth-1:0] wData,
	input  logic [irqBits-1:0]         irqIn,
	output logic [ioPkg::dataWidth-1:0] rData,
	output logic                       newIrq
);

	logic [irqBits-1:0] prevIn;
	logic [irqBits-1:0] mask;
	logic [irqBits-1:0] status;
	logic [irqBits-1:0] statusNext;
	logic [irqBits-1:0] setBits;
	logic               ackWrite;
	logic               maskWrite;

	// ----------------------------------------
	// Read side
	// ----------------------------------------
	always_comb begin
		rData = '0;
		rData[irqBits-1:0] = regHigh ? mask : status;
	end

	// ----------------------------------------
	// Edge detection
	// ----------------------------------------

	// Rising edge of an enabled source
	assign setBits = irqIn & ~prevIn & mask;

	// Only new arrivals are flagged to the CPU
	assign newIrq = |setBits;

	// ----------------------------------------
	// Status and mask update
	// ----------------------------------------
	assign ackWrite  = sel & write & ~regHigh;
	assign maskWrite = sel & write & regHigh;

	always_comb begin
		statusNext = status;
		if (ackWrite) begin
			statusNext = status & wData[irqBits-1:0];	// CPU acknowledge
		end
		// A source edge in the same cycle as an acknowledge wins
		statusNext = statusNext | setBits;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			prevIn <= '0;
			mask   <= '1;
			status <= '0;
		end else begin
			prevIn <= irqIn;
			status <= statusNext;
			if (maskWrite) begin
				mask <= wData[irqBits-1:0];
			end
		end
	end

	// ----------------------------------------
	// Checks
	// ----------------------------------------

	// A status bit can only rise from a masked edge one cycle before
	assert property (@(posedge clk) disable iff (reset)
		(status & ~$past(status) & ~$past(setBits)) == '0)
		else $error("irqController: status bit rose without a masked source edge");

	assert property (@(posedge clk) disable iff (reset)
		newIrq |-> (mask != '0))
		else $error("irqController: newIrq raised with every source masked");

endmodule

// File: source/rootCounter.sv
`timescale 1ns/100ps

module rootCounter #(
	parameter int width = 16
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       sel,
	input  logic [1:0]                 regOfs,
	input  logic                       write,
	input  logic [ioPkg::dataWidth-1:0] wData,
	output logic [ioPkg::dataWidth-1:0] rData,
	output logic                       irq
);

	logic [width-1:0]          value;
	logic [width-1:0]          target;
	logic [ioPkg::dataWidth-1:0] mode;
	logic                      enabled;
	logic                      atTarget;
	logic                      atMax;
	logic                      regWrite;

	assign enabled  = mode[ioPkg::modeEnable];
	assign atTarget = (value == target);
	assign atMax    = &value;
	assign regWrite = sel & write;

	// ----------------------------------------
	// Register read
	// ----------------------------------------
	always_comb begin
		rData = '0;
		case (regOfs)
			ioPkg::cntValueOfs:  rData[width-1:0] = value;
			ioPkg::cntModeOfs:   rData = mode;
			ioPkg::cntTargetOfs: rData[width-1:0] = target;
			default:             rData = '0;	// Hole in the block
		endcase
	end

	// ----------------------------------------
	// Interrupt pulse
	// ----------------------------------------

	// High for the single cycle the value sits on target or all ones
	assign irq = enabled &
		((atTarget & mode[ioPkg::modeIrqOnTarget]) |
		(atMax & mode[ioPkg::modeIrqOnOverflow]));

	// ----------------------------------------
	// Count and register writes
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			value  <= '0;
			mode   <= '0;
			target <= '0;
		end else begin
			if (enabled) begin
				if (atTarget && mode[ioPkg::modeResetOnTarget]) begin
					value <= '0;
				end else begin
					value <= value + 1'b1;	// Wraps to 0 past all ones
				end
			end

			// CPU writes take priority over counting
			if (regWrite) begin
				case (regOfs)
					ioPkg::cntValueOfs: begin
						value <= wData[width-1:0];
					end
					ioPkg::cntModeOfs: begin
						mode  <= wData;
						value <= '0;	// Mode write restarts the count
					end
					ioPkg::cntTargetOfs: begin
						target <= wData[width-1:0];
					end
					default: begin
					end
				endcase
			end
		end
	end

	// ----------------------------------------
	// Checks
	// ----------------------------------------

	// No pulse may leave the counter unless an irq mode asked for it
	assert property (@(posedge clk) disable iff (reset)
		irq |-> (mode[ioPkg::modeIrqOnTarget] | mode[ioPkg::modeIrqOnOverflow]))
		else $error("rootCounter: irq pulse with both irq mode bits clear");

endmodule

// File: source/regBridge.sv
`timescale 1ns/100ps

module regBridge #(
	parameter int cntCount = 3
) (
	input  logic                                     clk,
	input  logic                                     reset,
	input  logic                                     reqValid,
	input  logic                                     reqWrite,
	input  logic [7:0]                               reqAddr,
	input  logic [ioPkg::dataWidth-1:0]               reqWData,
	input  logic                                     rspReady,
	input  logic [ioPkg::dataWidth-1:0]               irqRData,
	input  logic [cntCount-1:0][ioPkg::dataWidth-1:0] cntRData,
	output logic                                     reqReady,
	output logic                                     rspValid,
	output logic [ioPkg::dataWidth-1:0]               rspData,
	output logic                                     irqSel,
	output logic                                     regHigh,
	output logic [cntCount-1:0]                      cntSel,
	output logic [1:0]                               regOfs,
	output logic                                     regWrite,
	output logic [ioPkg::dataWidth-1:0]               regWData
);

	logic                      accept;
	logic                      irqHit;
	logic [7:0]                cntRel;
	logic [cntCount-1:0]       cntHit;
	logic [ioPkg::dataWidth-1:0] rdWord;

	// Free when empty or when the held response leaves this cycle
	assign reqReady = !rspValid || rspReady;
	assign accept   = reqValid && reqReady;

	// ----------------------------------------
	// Address decode
	// ----------------------------------------
	assign irqHit  = (reqAddr == ioPkg::addrIrqStatus) || (reqAddr == ioPkg::addrIrqMask);
	assign regHigh = (reqAddr == ioPkg::addrIrqMask);
	assign cntRel  = reqAddr - ioPkg::addrCounterBase;
	assign regOfs  = 2'(cntRel % ioPkg::counterStride);

	always_comb begin
		for (int n = 0; n < cntCount; n++) begin
			cntHit[n] = (reqAddr >= ioPkg::addrCounterBase) &&
				(int'(cntRel) / ioPkg::counterStride == n) &&
				(regOfs <= ioPkg::cntTargetOfs);
		end
	end

	// Strobes fire only on the acceptance edge
	assign irqSel   = accept & irqHit;
	assign cntSel   = {cntCount{accept}} & cntHit;
	assign regWrite = accept & reqWrite;
	assign regWData = reqWData;

	// ----------------------------------------
	// Read mux and response register
	// ----------------------------------------
	always_comb begin
		rdWord = '0;	// Unmapped reads return zero
		if (irqHit) begin
			rdWord = irqRData;
		end
		for (int n = 0; n < cntCount; n++) begin
			if (cntHit[n]) begin
				rdWord = cntRData[n];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rspValid <= 1'b0;
		end else if (accept) begin
			rspValid <= 1'b1;
		end else if (rspReady) begin
			rspValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			rspData <= reqWrite ? '0 : rdWord;
		end
	end

	// Held response must not move under back-pressure
	assert property (@(posedge clk) disable iff (reset)
		(rspValid && !rspReady) |=> (rspValid && $stable(rspData)))
		else $error("regBridge: response changed while stalled");

endmodule

// File: source/ioSubsystem.sv
`timescale 1ns/100ps

module ioSubsystem #(
	parameter int counterWidth = 16
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       reqValid,
	input  logic                       reqWrite,
	input  logic [7:0]                 reqAddr,
	input  logic [ioPkg::dataWidth-1:0] reqWData,
	input  logic                       rspReady,
	input  logic                       vblRaw,	// Video clock domain
	input  logic                       gpuCmdIrq,
	input  logic                       cdromIrq,
	input  logic                       dmaIrq,
	input  logic                       padIrq,
	input  logic                       sioIrq,
	input  logic                       spuIrq,
	input  logic                       lightpenIrq,
	output logic                       reqReady,
	output logic                       rspValid,
	output logic [ioPkg::dataWidth-1:0] rspData,
	output logic                       newIrq
);

	// One counter per timer interrupt line
	localparam int counterCount = ioPkg::irqTimer2 - ioPkg::irqTimer0 + 1;

	logic                                         irqSel;
	logic                                         regHigh;
	logic [counterCount-1:0]                      cntSel;
	logic [1:0]                                   regOfs;
	logic                                         regWrite;
	logic [ioPkg::dataWidth-1:0]                   regWData;
	logic [ioPkg::dataWidth-1:0]                   irqRData;
	logic [counterCount-1:0][ioPkg::dataWidth-1:0] cntRData;
	logic [counterCount-1:0]                      cntIrq;
	logic                                         vblSync;
	logic [ioPkg::irqCount-1:0]                   irqLines;

	// ----------------------------------------
	// Source vector
	// ----------------------------------------
	assign irqLines[ioPkg::irqVbl]      = vblSync;
	assign irqLines[ioPkg::irqGpuCmd]   = gpuCmdIrq;
	assign irqLines[ioPkg::irqCdrom]    = cdromIrq;
	assign irqLines[ioPkg::irqDma]      = dmaIrq;
	assign irqLines[ioPkg::irqPad]      = padIrq;
	assign irqLines[ioPkg::irqSio]      = sioIrq;
	assign irqLines[ioPkg::irqSpu]      = spuIrq;
	assign irqLines[ioPkg::irqLightpen] = lightpenIrq;

	regBridge #(
		.cntCount(counterCount)
	) i_regBridge (
		.clk     (clk),
		.reset   (reset),
		.reqValid(reqValid),
		.reqWrite(reqWrite),
		.reqAddr (reqAddr),
		.reqWData(reqWData),
		.rspReady(rspReady),
		.irqRData(irqRData),
		.cntRData(cntRData),
		.reqReady(reqReady),
		.rspValid(rspValid),
		.rspData (rspData),
		.irqSel  (irqSel),
		.regHigh (regHigh),
		.cntSel  (cntSel),
		.regOfs  (regOfs),
		.regWrite(regWrite),
		.regWData(regWData)
	);

	sigXDomain i_sigXDomain (
		.clk  (clk),
		.reset(reset),
		.in   (vblRaw),
		.out  (vblSync)
	);

	irqController #(
		.irqBits(ioPkg::irqCount)
	) i_irqController (
		.clk    (clk),
		.reset  (reset),
		.sel    (irqSel),
		.regHigh(regHigh),
		.write  (regWrite),
		.wData  (regWData),
		.irqIn  (irqLines),
		.rData  (irqRData),
		.newIrq (newIrq)
	);

	// ----------------------------------------
	// Root counters
	// ----------------------------------------
	for (genvar n = 0; n < counterCount; n++) begin : g_counter
		rootCounter #(
			.width(counterWidth)
		) i_rootCounter (
			.clk   (clk),
			.reset (reset),
			.sel   (cntSel[n]),
			.regOfs(regOfs),
			.write (regWrite),
			.wData (regWData),
			.rData (cntRData[n]),
			.irq   (cntIrq[n])
		);

		assign irqLines[ioPkg::irqTimer0 + n] = cntIrq[n];
	end

endmodule

// File: test/ioSubsystemTb.sv
`timescale 1ns/100ps

module ioSubsystemTb;

	localparam int cycleLimit = 20000;	// About 400 transactions with stalls

	logic        clk;
	logic        reset;
	logic        reqValid;
	logic        reqWrite;
	logic [7:0]  reqAddr;
	logic [15:0] reqWData;
	logic        rspReady;
	logic        vblRaw;
	logic        gpuCmdIrq;
	logic        cdromIrq;
	logic        dmaIrq;
	logic        padIrq;
	logic        sioIrq;
	logic        spuIrq;
	logic        lightpenIrq;
	logic        reqReady;
	logic        rspValid;
	logic [15:0] rspData;
	logic        newIrq;

	logic [31:0] lcgState;
	logic [16:0] expQ[$];	// Check flag and expected data, oldest first
	logic [15:0] lastRsp;
	logic        accepted;
	logic [10:0] mMask;	// Reference model state
	logic [10:0] mStatus;
	logic [10:0] prevSrc;
	logic        vblP1;
	logic        vblP2;
	int          expPulses;
	int          obsPulses;
	int          errorCount;
	int          cycleCount;

	ioSubsystem #(.counterWidth(16)) i_ioSubsystem (.*);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout after %0d cycles, a transfer never completed", cycleCount);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] rand32();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return {lcgState[15:0], lcgState[31:16]};	// Strong bits at the bottom
	endfunction

	function automatic logic [7:0] cntAddr(input int n, input logic [1:0] ofs);
		return 8'(int'(ioPkg::addrCounterBase) + n * ioPkg::counterStride + int'(ofs));
	endfunction

	// ----------------------------------------
	// One clock: model, response check, drive
	// ----------------------------------------
	task automatic tick();
		logic [31:0] r;
		logic [10:0] cur;
		logic [10:0] sets;
		@(posedge clk);
		// Timer lines stay low while the counters are off
		cur = {lightpenIrq, spuIrq, sioIrq, padIrq, 3'b000, dmaIrq, cdromIrq, gpuCmdIrq, vblP2};
		if (reset) begin
			mMask   = 11'h7ff;
			mStatus = '0;
			prevSrc = '0;
			vblP1   = 1'b0;
			vblP2   = 1'b0;
		end else begin
			sets = cur & ~prevSrc & mMask;	// Masked rising edges
			mStatus |= sets;
			if (sets != '0) expPulses++;
			if (newIrq) obsPulses++;
			prevSrc = cur;
			vblP2   = vblP1;	// Two stages of synchronizer delay
			vblP1   = vblRaw;
		end
		if (rspValid && rspReady) begin
			lastRsp = rspData;
			if (expQ.size() == 0) begin
				$display("A response arrived with no request outstanding at %0t", $time);
				errorCount++;
			end else if (expQ[0][16] && rspData !== expQ[0][15:0]) begin
				$display("ERR %0t: response 0x%04h, expected 0x%04h",
					$time, rspData, expQ[0][15:0]);
				errorCount++;
			end
			if (expQ.size() != 0) void'(expQ.pop_front());
		end
		accepted = reqValid && reqReady;
		#2;
		r = rand32();
		rspReady = (r[1:0] != 2'b00);
	endtask

	// ----------------------------------------
	// Bus tasks
	// ----------------------------------------
	task automatic issue(input logic w, input logic [7:0] a, input logic [15:0] d,
		input logic chk, input logic [15:0] exp);
		reqValid = 1'b1;
		reqWrite = w;
		reqAddr  = a;
		reqWData = d;
		do tick(); while (!accepted);
		expQ.push_back({chk, exp});
		reqValid = 1'b0;
	endtask

	task automatic drain();
		while (expQ.size() != 0) tick();
	endtask

	task automatic busWrite(input logic [7:0] a, input logic [15:0] d);
		issue(1'b1, a, d, 1'b1, 16'h0000);	// Write responses carry zero
		drain();
	endtask

	task automatic busRead(input logic [7:0] a, output logic [15:0] d);
		issue(1'b0, a, 16'h0000, 1'b0, 16'h0000);
		drain();
		d = lastRsp;
	endtask

	task automatic readCheck(input logic [7:0] a, input logic [15:0] exp);
		logic [15:0] rd;
		busRead(a, rd);
		if (rd !== exp) begin
			$display("ERR %0t: read of 0x%02h gave 0x%04h, expected 0x%04h", $time, a, rd, exp);
			errorCount++;
		end
	endtask

	// Random edges on every source, then a quiet spell so the model settles
	task automatic toggleSources(input int cycles);
		logic [31:0] r;
		repeat (cycles) begin
			r = rand32();
			{lightpenIrq, spuIrq, sioIrq, padIrq, dmaIrq, cdromIrq, gpuCmdIrq, vblRaw} = r[7:0];
			tick();
		end
		repeat (3) tick();
	endtask

	initial begin
		logic [31:0] r;
		logic [15:0] rd;
		logic [15:0] word;
		logic [15:0] vals[3];
		int          tgt;
		lcgState = 32'he63f;
		reset    = 1'b1;
		reqValid = 1'b0;
		reqWrite = 1'b0;
		reqAddr  = 8'h00;
		reqWData = 16'h0000;
		rspReady = 1'b0;
		{lightpenIrq, spuIrq, sioIrq, padIrq, dmaIrq, cdromIrq, gpuCmdIrq, vblRaw} = 8'h00;
		repeat (10) tick();
		reset = 1'b0;

		// Reset values
		readCheck(ioPkg::addrIrqMask, 16'h07ff);
		readCheck(ioPkg::addrIrqStatus, 16'h0000);
		for (int n = 0; n < 3; n++) begin
			for (int o = 0; o < 3; o++) readCheck(cntAddr(n, 2'(o)), 16'h0000);
		end

		// ----------------------------------------
		// Random sources, masks and acknowledges
		// ----------------------------------------
		for (int i = 0; i < 80; i++) begin
			r = rand32();
			if (r[3:0] == 4'd0) begin
				word = 16'(rand32());
				busWrite(ioPkg::addrIrqMask, word);
				mMask = word[10:0];
			end
			toggleSources(1 + int'(r[6:4]));
			busRead(ioPkg::addrIrqStatus, rd);
			if (rd !== {5'b0, mStatus}) begin
				$display("ERR %0t: status 0x%04h, model 0x%04h", $time, rd, {5'b0, mStatus});
				errorCount++;
			end
			if (r[9:8] == 2'd0) begin
				word = 16'(rand32());
				busWrite(ioPkg::addrIrqStatus, word);
				mStatus &= word[10:0];	// Ack ANDs into status
				repeat (3) tick();
				readCheck(ioPkg::addrIrqStatus, {5'b0, mStatus});
			end
		end
		if (obsPulses != expPulses) begin
			$display("ERR %0t: %0d newIrq pulses, model expects %0d",
				$time, obsPulses, expPulses);
			errorCount++;
		end

		// Overlapped requests under back-pressure, answered in order
		for (int n = 0; n < 3; n++) begin
			vals[n] = 16'(rand32());
			issue(1'b1, cntAddr(n, ioPkg::cntTargetOfs), vals[n], 1'b1, 16'h0000);
		end
		issue(1'b0, 8'h0c, 16'h0000, 1'b1, 16'h0000);	// Unmapped address
		for (int n = 0; n < 3; n++) begin
			issue(1'b0, cntAddr(n, ioPkg::cntTargetOfs), 16'h0000, 1'b1, vals[n]);
		end
		drain();

		// ----------------------------------------
		// Counters with a small target
		// ----------------------------------------
		busWrite(ioPkg::addrIrqMask, 16'h07ff);
		busWrite(ioPkg::addrIrqStatus, 16'h0000);
		for (int n = 0; n < 3; n++) begin
			r = rand32();
			tgt = 2 + int'(r[3:0]) % 13;
			busWrite(cntAddr(n, ioPkg::cntTargetOfs), 16'(tgt));
			busWrite(cntAddr(n, ioPkg::cntModeOfs), 16'((1 << ioPkg::modeEnable) |
				(1 << ioPkg::modeResetOnTarget) | (1 << ioPkg::modeIrqOnTarget)));
			repeat (2 * (tgt + 2)) tick();
			busRead(ioPkg::addrIrqStatus, rd);
			if (!rd[ioPkg::irqTimer0 + n]) begin
				$display("ERR %0t: timer %0d status bit not set, target %0d", $time, n, tgt);
				errorCount++;
			end
			repeat (4) begin
				busRead(cntAddr(n, ioPkg::cntValueOfs), rd);
				if (int'(rd) > tgt) begin
					$display("ERR %0t: timer %0d value %0d above target %0d", $time, n, rd, tgt);
					errorCount++;
				end
			end
			busWrite(cntAddr(n, ioPkg::cntModeOfs), 16'h0000);
			busWrite(ioPkg::addrIrqStatus, 16'h0000);
		end

		$display("Run complete: %0d errors, %0d newIrq pulses, %0d cycles",
			errorCount, obsPulses, cycleCount);
		if (errorCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: ioSubsystem.f
source/ioPkg.sv
source/sigXDomain.sv
source/irqController.sv
source/rootCounter.sv
source/regBridge.sv
source/ioSubsystem.sv
test/ioSubsystemTb.sv

// File: runSim.sh
#!/bin/sh
# Compile with Verilator, run, and judge the result from the log
verilator --binary --timing --assert -Wno-fatal --top-module ioSubsystemTb \
	-f ioSubsystem.f -o ioSubsystemSim > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/ioSubsystemSim > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log && exit 0 || exit 1
